//--- Bender.yml
package:
  name: exu

sources:
  - include_dirs:
      - src
    files:
      - src/exu_pkg.sv
      - src/exu_operand_mux.sv
      - src/exu_alu.sv
      - src/exu_ghr.sv
      - src/exu_pipe_ctl.sv
      - src/exu_top.sv
  - target: test
    include_dirs:
      - src
    files:
      - dv/tb_exu.sv

//--- compile.f
+incdir+src
src/exu_pkg.sv
src/exu_operand_mux.sv
src/exu_alu.sv
src/exu_ghr.sv
src/exu_pipe_ctl.sv
src/exu_top.sv
dv/tb_exu.sv

//--- dv/tb_exu.sv
// Self-checking testbench for the integer execute stage against a reference model
`timescale 1ns/1ps
`include "exu_macros.svh"

module tb_exu;

   localparam int N_RANDOM    = 400;
   localparam int N_DIRECTED  = 100;                         // Upper bound of directed cycles
   localparam int CYCLE_LIMIT = 4 * (N_RANDOM + N_DIRECTED);

   // All DUT inputs of one D cycle
   typedef struct packed {
      logic [1:0]            data_en;
      logic [1:0]            ctl_en;
      exu_pkg::alu_pkt_t     ap;
      logic                  decode;
      exu_pkg::predict_pkt_t predict;
      exu_pkg::byp_sel_t     sel_rs1;
      exu_pkg::byp_sel_t     sel_rs2;
      exu_pkg::byp_data_t    byp;
      exu_pkg::word_t        gpr_rs1;
      exu_pkg::word_t        gpr_rs2;
      exu_pkg::word_t        immed;
      logic                  rs1_en;
      logic                  rs2_en;
      logic                  select_pc;
      exu_pkg::pc_t          pc;
      logic [12:1]           br_immed;
      exu_pkg::pc_t          npc_x;
      logic                  lower;
      exu_pkg::pc_t          path_r;
   } stim_t;

   // Model view of the X and R stage state
   typedef struct packed {
      exu_pkg::word_t        result_x;
      exu_pkg::pc_t          pc_x;
      exu_pkg::pc_t          path_x;
      exu_pkg::predict_pkt_t pkt_x;
      logic                  upper_x;
      logic                  correct_x;
      logic                  br_valid_x;
      logic                  br_taken_x;
      logic                  correct_r;
      exu_pkg::predict_pkt_t pkt_r;
      exu_pkg::pc_t          path_r;
      exu_pkg::pc_t          npc_r;
      exu_pkg::ghr_t         ghr_d;
      exu_pkg::ghr_t         ghr_x;
   } model_t;

   typedef struct packed {
      exu_pkg::word_t        result_x;
      exu_pkg::pc_t          pc_x;
      logic                  flush;
      exu_pkg::pc_t          flush_path;
      exu_pkg::predict_pkt_t mp_pkt;
      exu_pkg::ghr_t         mp_fghr;
      exu_pkg::br_info_t     br_r;
      exu_pkg::pc_t          npc_r;
   } expect_t;

   logic                  clk;
   logic                  arst_n;
   logic [31:0]           rng;
   int                    errors;
   int                    checks;
   int                    cycles;
   stim_t                 stim;
   model_t                ms;
   model_t                ms_next;
   expect_t               ex;
   exu_pkg::word_t        result_x;
   exu_pkg::pc_t          pc_x;
   logic                  flush_final;
   exu_pkg::pc_t          flush_path_final;
   exu_pkg::predict_pkt_t mp_pkt;
   exu_pkg::ghr_t         mp_fghr;
   exu_pkg::br_info_t     br_r;
   exu_pkg::pc_t          npc_r;

   exu_top uut (
      .clk                  (clk),
      .i_arst_n             (arst_n),
      .i_data_en            (stim.data_en),
      .i_ctl_en             (stim.ctl_en),
      .i_ap                 (stim.ap),
      .i_alu_decode_d       (stim.decode),
      .i_predict_d          (stim.predict),
      .i_byp_sel_rs1        (stim.sel_rs1),
      .i_byp_sel_rs2        (stim.sel_rs2),
      .i_byp_data           (stim.byp),
      .i_gpr_rs1            (stim.gpr_rs1),
      .i_gpr_rs2            (stim.gpr_rs2),
      .i_immed              (stim.immed),
      .i_rs1_en             (stim.rs1_en),
      .i_rs2_en             (stim.rs2_en),
      .i_select_pc          (stim.select_pc),
      .i_pc_d               (stim.pc),
      .i_br_immed           (stim.br_immed),
      .i_pred_correct_npc_x (stim.npc_x),
      .i_flush_lower_r      (stim.lower),
      .i_flush_path_r       (stim.path_r),
      .o_i0_result_x        (result_x),
      .o_i0_pc_x            (pc_x),
      .o_flush_final        (flush_final),
      .o_flush_path_final   (flush_path_final),
      .o_mp_pkt             (mp_pkt),
      .o_mp_fghr            (mp_fghr),
      .o_br_r               (br_r),
      .o_npc_r              (npc_r)
   );

   always #4 clk = ~clk;                                     // 8 ns period

   function automatic logic [31:0] xorshift32();
      logic [31:0] x;
      x   = rng;
      x   = x ^ (x << 13);
      x   = x ^ (x >> 17);
      x   = x ^ (x << 5);
      rng = x;
      return x;
   endfunction

   // 0 add, 1 sub, 2 and, 3 or, 4 xor, 5 slt, 7 beq, 8 bne, 9 blt, 10 bge, 11 jal
   function automatic exu_pkg::alu_pkt_t op_pkt(input logic [3:0] k);
      exu_pkg::alu_pkt_t p;
      case (k)
         4'd12:   p = 12'b000001100000;                      // sltu
         4'd13:   p = 12'b000000100100;                      // bltu
         4'd14:   p = 12'b000000100010;                      // bgeu
         4'd15:   p = 12'b000000000001;                      // jal
         default: p = 12'b1 << (11 - k);                     // 6 is a lone unsign, a nop
      endcase
      return p;
   endfunction

   function automatic exu_pkg::byp_sel_t one_hot_sel(input logic [3:0] r4);
      return (r4[3:2] == 2'b11) ? (4'b0001 << r4[1:0]) : 4'b0000;
   endfunction

   function automatic exu_pkg::word_t bypass_word(input exu_pkg::byp_sel_t sel,
                                                  input exu_pkg::byp_data_t byp,
                                                  input exu_pkg::word_t x);
      exu_pkg::word_t w;
      w = '0;
      if (sel[0]) w = w | byp.result_r;
      if (sel[1]) w = w | byp.lsu_m;
      if (sel[2]) w = w | x;                                 // Previous X result
      if (sel[3]) w = w | byp.nonblock;
      return w;
   endfunction

   function automatic exu_pkg::br_info_t br_report(input exu_pkg::predict_pkt_t p);
      exu_pkg::br_info_t r;
      r.valid  = p.valid;
      r.mp     = p.misp;
      r.middle = p.pc4 ^ p.boffset;
      r.way    = p.way;
      r.hist   = p.valid ? p.hist : 2'b00;
      return r;
   endfunction

   // Expected outputs of this cycle and the state after the next rising edge
   function automatic model_t exu_model(input model_t s, input stim_t t, output expect_t e);
      model_t                n;
      exu_pkg::predict_pkt_t pk;
      exu_pkg::word_t        a;
      exu_pkg::word_t        b;
      exu_pkg::word_t        sum;
      exu_pkg::word_t        res;
      exu_pkg::pc_t          path;
      logic                  lt;
      logic                  taken;
      logic                  live;
      logic                  misp;
      if (|t.sel_rs1)       a = bypass_word(t.sel_rs1, t.byp, s.result_x);
      else if (t.select_pc) a = {t.pc, 1'b0};
      else if (t.rs1_en)    a = t.gpr_rs1;
      else                  a = '0;
      if (|t.sel_rs2)    b = bypass_word(t.sel_rs2, t.byp, s.result_x);
      else if (t.rs2_en) b = t.gpr_rs2;
      else               b = t.immed;
      lt  = t.ap.unsign ? (a < b) : ($signed(a) < $signed(b));
      sum = a + b;
      res = '0;
      if (t.ap.add)  res = res | sum;
      if (t.ap.sub)  res = res | (a - b);
      if (t.ap.land) res = res | (a & b);
      if (t.ap.lor)  res = res | (a | b);
      if (t.ap.lxor) res = res | (a ^ b);
      if (t.ap.slt)  res = res | {{(`EXU_XLEN-1){1'b0}}, lt};
      if (t.ap.jal)  res = res | ({t.pc, 1'b0} + 32'd4);   // Link address
      taken = (t.ap.beq & (a == b)) | (t.ap.bne & (a != b)) |
              (t.ap.blt & lt) | (t.ap.bge & ~lt) | t.ap.jal;
      live  = t.decode & (t.ap.beq | t.ap.bne | t.ap.blt | t.ap.bge | t.ap.jal) &
              ~s.upper_x & ~t.lower;
      misp  = live & (taken ^ t.predict.ataken);
      if (!taken)        path = t.pc + (t.predict.pc4 ? 31'd2 : 31'd1);
      else if (t.ap.jal) path = sum[`EXU_XLEN-1:1];
      else               path = t.pc + {{(`EXU_XLEN-13){t.br_immed[12]}}, t.br_immed};
      pk         = t.predict;
      pk.valid   = t.predict.valid & t.decode;
      pk.ataken  = taken & t.decode;
      pk.misp    = misp;
      pk.boffset = t.pc[1];
      e.result_x   = s.result_x;
      e.pc_x       = s.pc_x;
      e.flush      = t.lower | misp;
      e.flush_path = t.lower ? t.path_r : (misp ? path : '0);
      e.mp_pkt     = s.upper_x ? s.pkt_x : '0;
      e.mp_fghr    = (s.upper_x & ~t.lower) ? s.ghr_d : s.ghr_x;
      e.br_r       = br_report(s.pkt_r);
      e.npc_r      = s.correct_r ? s.npc_r : s.path_r;
      n = s;
      if (t.data_en[1]) begin
         n.result_x = res;
         n.pc_x     = t.pc;
         n.path_x   = path;
         n.pkt_x    = pk;
      end
      if (t.ctl_en[1]) begin
         n.upper_x    = misp;
         n.correct_x  = live & ~misp;
         n.br_valid_x = pk.valid & ~s.upper_x & ~t.lower;
         n.br_taken_x = pk.ataken;
         if (s.br_valid_x) n.ghr_x = {s.ghr_x[`EXU_GHR_SIZE-2:0], s.br_taken_x};
      end
      if (t.ctl_en[0]) begin
         n.correct_r = s.correct_x;
         n.pkt_r     = s.pkt_x;
      end
      if (t.data_en[0]) begin
         n.path_r = s.path_x;
         n.npc_r  = t.npc_x;
      end
      if (t.lower)                    n.ghr_d = s.ghr_x;   // Trap restores from X
      else if (pk.valid & ~s.upper_x) n.ghr_d = {s.ghr_d[`EXU_GHR_SIZE-2:0], pk.ataken};
      return n;
   endfunction

   task automatic check_value(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
      checks++;
      assert (got === exp) else begin
         errors++;
         $display("** Error: %s = 0x%h, expected 0x%h at %0t", name, got, exp, $time);
      end
   endtask

   task automatic idle_stim();
      stim         = '0;
      stim.data_en = 2'b11;
      stim.ctl_en  = 2'b11;
   endtask

   task automatic random_instr();
      logic [31:0] r;
      r = xorshift32();
      stim.ap            = op_pkt(r[3:0]);
      stim.decode        = (r[6:4] != 3'd0);
      stim.predict       = r[15:8];
      stim.predict.valid = r[16] | r[17];
      stim.sel_rs1       = one_hot_sel(r[21:18]);
      stim.sel_rs2       = one_hot_sel(r[25:22]);
      stim.rs1_en        = r[26] | r[27];
      stim.rs2_en        = r[28];
      stim.select_pc     = (r[31:29] == 3'd0);
      r = xorshift32();
      stim.lower         = (r[3:0] == 4'd0);
      stim.br_immed      = r[15:4];
      stim.data_en       = (r[18:16] == 3'd0) ? r[20:19] : 2'b11;   // Occasional stall
      stim.ctl_en        = (r[18:16] == 3'd0) ? r[22:21] : 2'b11;
      stim.gpr_rs1       = xorshift32();
      stim.gpr_rs2       = r[23] ? stim.gpr_rs1 : xorshift32();     // Equal for branches
      stim.immed         = xorshift32();
      stim.byp.result_r  = xorshift32();
      stim.byp.lsu_m     = xorshift32();
      stim.byp.nonblock  = xorshift32();
      r = xorshift32();
      stim.pc            = r[31:1];
      r = xorshift32();
      stim.npc_x         = r[31:1];
      r = xorshift32();
      stim.path_r        = r[31:1];
   endtask

   task automatic alu_op(input logic [3:0] k, input exu_pkg::byp_sel_t sel1,
                         input exu_pkg::byp_sel_t sel2, input logic pc_rs1);
      random_instr();
      stim.ap            = op_pkt(k);
      stim.decode        = 1'b1;
      stim.predict.valid = 1'b0;
      stim.sel_rs1       = sel1;
      stim.sel_rs2       = sel2;
      stim.select_pc     = pc_rs1;
      stim.rs1_en        = 1'b1;
      stim.rs2_en        = 1'b1;
      stim.lower         = 1'b0;
      stim.data_en       = 2'b11;
      stim.ctl_en        = 2'b11;
   endtask

   task automatic branch_op(input logic [3:0] k, input exu_pkg::word_t a,
                            input exu_pkg::word_t b, input logic ataken, input logic lower);
      alu_op(k, 4'b0000, 4'b0000, 1'b0);
      stim.predict.valid  = 1'b1;
      stim.predict.ataken = ataken;
      stim.gpr_rs1        = a;
      stim.gpr_rs2        = b;
      stim.lower          = lower;
   endtask

   always @(posedge clk) begin
      if (arst_n) begin
         ms_next = exu_model(ms, stim, ex);
         check_value("o_i0_result_x", result_x, ex.result_x);
         check_value("o_i0_pc_x", {1'b0, pc_x}, {1'b0, ex.pc_x});
         check_value("o_flush_final", {31'b0, flush_final}, {31'b0, ex.flush});
         check_value("o_flush_path_final", {1'b0, flush_path_final}, {1'b0, ex.flush_path});
         check_value("o_mp_pkt", {24'b0, mp_pkt}, {24'b0, ex.mp_pkt});
         check_value("o_mp_fghr", {24'b0, mp_fghr}, {24'b0, ex.mp_fghr});
         check_value("o_br_r", {26'b0, br_r}, {26'b0, ex.br_r});
         check_value("o_npc_r", {1'b0, npc_r}, {1'b0, ex.npc_r});
         ms = ms_next;
      end
   end

   always @(posedge clk) begin
      cycles++;
      if (cycles >= CYCLE_LIMIT) begin
         $display("Timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
         $display("TEST RESULT: FAIL");
         $finish;
      end
   end

   initial begin
      rng    = 32'h839a8ee9;
      errors = 0;
      checks = 0;
      cycles = 0;
      clk    = 1'b0;
      arst_n = 1'b0;
      stim   = '0;
      ms     = '0;
      repeat (5) @(posedge clk);
      @(negedge clk);
      arst_n = 1'b1;
      for (int i = 0; i < N_RANDOM; i++) begin
         @(negedge clk);
         random_instr();
      end
      // X result into rs1 with each external source on rs2
      for (int k = 0; k < 4; k++) begin
         @(negedge clk);
         alu_op(4'd0, 4'b0000, 4'b0000, 1'b0);
         @(negedge clk);
         alu_op(4'd1, 4'b0100, exu_pkg::byp_sel_t'(1 << k), 1'b0);
      end
      @(negedge clk);
      alu_op(4'd4, 4'b0000, 4'b0100, 1'b1);                 // PC on rs1
      @(negedge clk);
      branch_op(4'd7, 32'h1234, 32'h1234, 1'b1, 1'b0);      // beq, correctly predicted
      @(negedge clk);
      branch_op(4'd8, 32'h55, 32'h55, 1'b1, 1'b0);          // bne, mispredicted
      @(negedge clk);
      branch_op(4'd9, 32'hffff_fff0, 32'h10, 1'b0, 1'b0);   // Shadow of the upper flush
      @(negedge clk);
      branch_op(4'd11, 32'h100, 32'h20, 1'b0, 1'b0);        // jal, mispredicted
      @(negedge clk);
      alu_op(4'd2, 4'b0000, 4'b0000, 1'b0);
      @(negedge clk);
      branch_op(4'd10, 32'h1, 32'h2, 1'b1, 1'b1);           // Trap flush wins
      @(negedge clk);
      branch_op(4'd8, 32'h7, 32'h9, 1'b0, 1'b0);            // Mispredict, then stall
      for (int k = 0; k < 6; k++) begin
         @(negedge clk);
         random_instr();
         stim.data_en = 2'b00;
         stim.ctl_en  = 2'b00;
      end
      for (int k = 0; k < 3; k++) begin
         @(negedge clk);
         random_instr();
         stim.data_en = 2'b01;                               // X holds, R loads
         stim.ctl_en  = 2'b01;
      end
      for (int k = 0; k < 3; k++) begin
         @(negedge clk);
         idle_stim();
      end
      @(negedge clk);
      $display("Checks: %0d, errors: %0d", checks, errors);
      if (errors == 0) begin
         $display("TEST RESULT: PASS");
      end else begin
         $display("TEST RESULT: FAIL");
      end
      $finish;
   end

endmodule

//--- src/exu_alu.sv
// Single-cycle ALU, D-stage branch resolution and X-stage result registers
`timescale 1ns/1ps
`include "exu_macros.svh"

module exu_alu (
   input  logic                  clk,
   input  logic                  i_arst_n,
   input  logic                  i_enable,         // X data enable
   input  logic                  i_valid_d,        // ALU decode valid
   input  exu_pkg::alu_pkt_t     i_ap,
   input  exu_pkg::word_t        i_a,
   input  exu_pkg::word_t        i_b,
   input  exu_pkg::pc_t          i_pc_d,
   input  logic [12:1]           i_br_immed,       // Branch offset in halfwords
   input  exu_pkg::predict_pkt_t i_predict_d,
   input  logic                  i_flush_upper_x,
   input  logic                  i_flush_lower_r,
   output exu_pkg::word_t        o_result_x,
   output exu_pkg::pc_t          o_pc_x,
   output logic                  o_flush_upper_d,
   output exu_pkg::pc_t          o_flush_path_d,
   output exu_pkg::predict_pkt_t o_predict_d,
   output logic                  o_pred_correct_d
);

   exu_pkg::word_t aout;
   exu_pkg::word_t lout;
   exu_pkg::word_t link;
   exu_pkg::word_t result_d;
   exu_pkg::pc_t   br_target;
   exu_pkg::pc_t   seq_next;
   logic           eq;
   logic           lt;
   logic           any_br;
   logic           actual_taken;
   logic           live;
   logic           misp;

   // Two's complement subtract when sub is set
   assign aout = i_a + (i_ap.sub ? ~i_b : i_b) + exu_pkg::word_t'(i_ap.sub);

   assign lout = ({`EXU_XLEN{i_ap.land}} & (i_a & i_b)) |
                 ({`EXU_XLEN{i_ap.lor}}  & (i_a | i_b)) |
                 ({`EXU_XLEN{i_ap.lxor}} & (i_a ^ i_b));

   assign eq = (i_a == i_b);
   assign lt = i_ap.unsign ? (i_a < i_b) : ($signed(i_a) < $signed(i_b));

   assign link = {i_pc_d, 1'b0} + exu_pkg::word_t'(4);   // Return address

   assign result_d = lout                                              |
                     ({`EXU_XLEN{i_ap.add | i_ap.sub}} & aout)         |
                     ({`EXU_XLEN{i_ap.slt}}            & exu_pkg::word_t'(lt)) |
                     ({`EXU_XLEN{i_ap.jal}}            & link);

   assign any_br = i_ap.beq | i_ap.bne | i_ap.blt | i_ap.bge | i_ap.jal;
   assign live   = i_valid_d & any_br & ~i_flush_upper_x & ~i_flush_lower_r;

   assign actual_taken = (i_ap.beq &  eq) | (i_ap.bne & ~eq) |
                         (i_ap.blt &  lt) | (i_ap.bge & ~lt) | i_ap.jal;

   assign misp = live & (actual_taken ^ i_predict_d.ataken);

   // Sign-extended halfword offset from the branch PC
   assign br_target = i_pc_d + exu_pkg::pc_t'({{(`EXU_XLEN-13){i_br_immed[12]}}, i_br_immed});
   assign seq_next  = i_pc_d + (i_predict_d.pc4 ? exu_pkg::pc_t'(2) : exu_pkg::pc_t'(1));

   assign o_flush_upper_d  = misp;
   assign o_pred_correct_d = live & ~misp;
   assign o_flush_path_d   = ~actual_taken ? seq_next         :
                             i_ap.jal      ? aout[`EXU_XLEN-1:1] : br_target;

   always_comb begin
      o_predict_d         = i_predict_d;
      o_predict_d.valid   = i_predict_d.valid & i_valid_d;
      o_predict_d.ataken  = actual_taken & i_valid_d;
      o_predict_d.misp    = misp;
      o_predict_d.boffset = i_pc_d[1];                    // Start of instruction
   end

   always_ff @(posedge clk or negedge i_arst_n) begin
      if (!i_arst_n) begin
         o_result_x <= '0;
         o_pc_x     <= '0;
      end else if (i_enable) begin
         o_result_x <= result_d;
         o_pc_x     <= i_pc_d;
      end
   end

endmodule

//--- src/exu_ghr.sv
// Global branch history kept at D and X with recovery history select
`timescale 1ns/1ps
`include "exu_macros.svh"

module exu_ghr (
   input  logic                  clk,
   input  logic                  i_arst_n,
   input  logic                  i_ctl_en_x,
   input  exu_pkg::predict_pkt_t i_predict_d,      // Resolved packet from the ALU
   input  logic                  i_valid_d,
   input  logic                  i_br_valid_x,
   input  logic                  i_br_taken_x,
   input  logic                  i_flush_upper_x,
   input  logic                  i_flush_lower_r,
   output exu_pkg::ghr_t         o_mp_fghr
);

   exu_pkg::ghr_t ghr_d;
   exu_pkg::ghr_t ghr_d_ns;
   exu_pkg::ghr_t ghr_x;
   exu_pkg::ghr_t ghr_x_ns;
   logic          valid_d;

   assign valid_d = i_predict_d.valid & i_valid_d & ~i_flush_upper_x & ~i_flush_lower_r;

   // Trap flush restores the speculative history from X
   assign ghr_d_ns = i_flush_lower_r ? ghr_x                                             :
                     valid_d         ? {ghr_d[`EXU_GHR_SIZE-2:0], i_predict_d.ataken}     :
                                       ghr_d;

   assign ghr_x_ns = i_br_valid_x ? {ghr_x[`EXU_GHR_SIZE-2:0], i_br_taken_x} : ghr_x;

   always_ff @(posedge clk or negedge i_arst_n) begin
      if (!i_arst_n) begin
         ghr_d <= '0;
         ghr_x <= '0;
      end else begin
         ghr_d <= ghr_d_ns;
         if (i_ctl_en_x) begin
            ghr_x <= ghr_x_ns;
         end
      end
   end

   assign o_mp_fghr = (i_flush_upper_x & ~i_flush_lower_r) ? ghr_d : ghr_x;

endmodule

//--- src/exu_macros.svh
// Execute stage sizing macros for data width, branch history and bypass sources
`ifndef EXU_MACROS_SVH
`define EXU_MACROS_SVH

// Data path width in bits
`define EXU_XLEN 32

// Global branch history length
`define EXU_GHR_SIZE 8

// One-hot bypass sources: R result, LSU M result, X result, non-blocking load
`define EXU_BYP_SRCS 4

`endif

//--- src/exu_operand_mux.sv
// Operand select for the ALU with one-hot bypass, PC, GPR and immediate sources
`timescale 1ns/1ps
`include "exu_macros.svh"

module exu_operand_mux (
   input  exu_pkg::byp_sel_t  i_byp_sel_rs1,
   input  exu_pkg::byp_sel_t  i_byp_sel_rs2,
   input  exu_pkg::byp_data_t i_byp_data,
   input  exu_pkg::word_t     i_result_x,         // Own X-stage result
   input  exu_pkg::word_t     i_gpr_rs1,
   input  exu_pkg::word_t     i_gpr_rs2,
   input  exu_pkg::word_t     i_immed,
   input  logic               i_rs1_en,           // Qualify GPR rs1
   input  logic               i_rs2_en,           // Qualify GPR rs2
   input  logic               i_select_pc,        // PC to rs1
   input  exu_pkg::pc_t       i_pc_d,
   output exu_pkg::word_t     o_rs1_d,
   output exu_pkg::word_t     o_rs2_d
);

   localparam int NSRC = `EXU_BYP_SRCS;

   logic [NSRC-1:0][`EXU_XLEN-1:0] byp_src;
   exu_pkg::word_t                 byp_rs1;
   exu_pkg::word_t                 byp_rs2;

   // AND-OR of the selected sources, select is one-hot
   function automatic exu_pkg::word_t byp_pick(
      input exu_pkg::byp_sel_t              sel,
      input logic [NSRC-1:0][`EXU_XLEN-1:0] src
   );
      exu_pkg::word_t acc;
      int             i;
      acc = '0;
      for (i = 0; i < NSRC; i++) begin
         acc = acc | ({`EXU_XLEN{sel[i]}} & src[i]);
      end
      return acc;
   endfunction

   // Bit order matches the select encoding
   assign byp_src = {i_byp_data.nonblock, i_result_x, i_byp_data.lsu_m, i_byp_data.result_r};

   assign byp_rs1 = byp_pick(i_byp_sel_rs1, byp_src);
   assign byp_rs2 = byp_pick(i_byp_sel_rs2, byp_src);

   assign o_rs1_d = (|i_byp_sel_rs1) ? byp_rs1            :
                    i_select_pc      ? {i_pc_d, 1'b0}     :   // Link base for jal
                    i_rs1_en         ? i_gpr_rs1          : '0;

   assign o_rs2_d = (|i_byp_sel_rs2) ? byp_rs2   :
                    i_rs2_en         ? i_gpr_rs2 : i_immed;

endmodule

//--- src/exu_pipe_ctl.sv
// D to X to R predict pipe with final flush, mispredict packet and next-PC select
`timescale 1ns/1ps

module exu_pipe_ctl (
   input  logic                  clk,
   input  logic                  i_arst_n,
   input  logic [1:0]            i_data_en,          // {x, r}
   input  logic [1:0]            i_ctl_en,           // {x, r}
   input  logic                  i_flush_upper_d,
   input  exu_pkg::pc_t          i_flush_path_d,
   input  exu_pkg::predict_pkt_t i_predict_d,
   input  logic                  i_pred_correct_d,
   input  logic                  i_flush_lower_r,
   input  exu_pkg::pc_t          i_flush_path_r,
   input  exu_pkg::pc_t          i_pred_correct_npc_x,
   output logic                  o_ctl_en_x,
   output logic                  o_data_en_x,
   output logic                  o_flush_upper_x,
   output logic                  o_br_valid_x,
   output logic                  o_br_taken_x,
   output logic                  o_flush_final,
   output exu_pkg::pc_t          o_flush_path_final,
   output exu_pkg::predict_pkt_t o_mp_pkt,
   output exu_pkg::br_info_t     o_br_r,
   output exu_pkg::pc_t          o_npc_r
);

   logic                  data_en_r;
   logic                  ctl_en_r;
   logic                  br_valid_d;
   logic                  pred_correct_x;
   logic                  pred_correct_r;
   exu_pkg::pc_t          flush_path_x;
   exu_pkg::pc_t          flush_path_upper_r;
   exu_pkg::pc_t          pred_npc_r;
   exu_pkg::predict_pkt_t predict_x;
   exu_pkg::predict_pkt_t predict_r;

   assign o_data_en_x = i_data_en[1];
   assign o_ctl_en_x  = i_ctl_en[1];
   assign data_en_r   = i_data_en[0];
   assign ctl_en_r    = i_ctl_en[0];

   assign br_valid_d = i_predict_d.valid & ~o_flush_upper_x & ~i_flush_lower_r;

   always_ff @(posedge clk or negedge i_arst_n) begin
      if (!i_arst_n) begin
         flush_path_x <= '0;
         predict_x    <= '0;
      end else if (o_data_en_x) begin
         flush_path_x <= i_flush_path_d;
         predict_x    <= i_predict_d;
      end
   end

   always_ff @(posedge clk or negedge i_arst_n) begin
      if (!i_arst_n) begin
         o_flush_upper_x <= 1'b0;
         pred_correct_x  <= 1'b0;
         o_br_valid_x    <= 1'b0;
         o_br_taken_x    <= 1'b0;
      end else if (o_ctl_en_x) begin
         o_flush_upper_x <= i_flush_upper_d;
         pred_correct_x  <= i_pred_correct_d;
         o_br_valid_x    <= br_valid_d;
         o_br_taken_x    <= i_predict_d.ataken;
      end
   end

   always_ff @(posedge clk or negedge i_arst_n) begin
      if (!i_arst_n) begin
         pred_correct_r <= 1'b0;
         predict_r      <= '0;
      end else if (ctl_en_r) begin
         pred_correct_r <= pred_correct_x;
         predict_r      <= predict_x;
      end
   end

   always_ff @(posedge clk or negedge i_arst_n) begin
      if (!i_arst_n) begin
         flush_path_upper_r <= '0;
         pred_npc_r         <= '0;
      end else if (data_en_r) begin
         flush_path_upper_r <= flush_path_x;
         pred_npc_r         <= i_pred_correct_npc_x;
      end
   end

   // Trap flush is older than a branch flush
   assign o_flush_final      = i_flush_lower_r | i_flush_upper_d;
   assign o_flush_path_final = i_flush_lower_r ? i_flush_path_r :
                               i_flush_upper_d ? i_flush_path_d : '0;

   assign o_mp_pkt = o_flush_upper_x ? predict_x : '0;

   assign o_br_r.valid  = predict_r.valid;
   assign o_br_r.mp     = predict_r.misp;
   assign o_br_r.middle = predict_r.pc4 ^ predict_r.boffset;
   assign o_br_r.way    = predict_r.way;
   assign o_br_r.hist   = {2{predict_r.valid}} & predict_r.hist;

   assign o_npc_r = pred_correct_r ? pred_npc_r : flush_path_upper_r;

endmodule

//--- src/exu_pkg.sv
// Shared vector and packet types of the integer execute stage
`include "exu_macros.svh"

package exu_pkg;

   typedef logic [`EXU_XLEN-1:0]     word_t;     // Data word
   typedef logic [`EXU_XLEN-1:1]     pc_t;       // Halfword-aligned PC
   typedef logic [`EXU_GHR_SIZE-1:0] ghr_t;      // Global history
   typedef logic [`EXU_BYP_SRCS-1:0] byp_sel_t;  // One-hot bypass select

   typedef struct packed {
      word_t result_r;                           // R-stage result
      word_t lsu_m;                              // LSU M-stage result
      word_t nonblock;                           // Non-blocking load data
   } byp_data_t;

   // Decoded ALU operation, one flag per function
   typedef struct packed {
      logic add;
      logic sub;
      logic land;
      logic lor;
      logic lxor;
      logic slt;
      logic unsign;                              // Unsigned compare
      logic beq;
      logic bne;
      logic blt;
      logic bge;
      logic jal;
   } alu_pkt_t;

   typedef struct packed {
      logic       valid;
      logic       ataken;                        // Predicted, later actual, taken
      logic       misp;
      logic       pc4;                           // 4-byte instruction
      logic       boffset;
      logic       way;
      logic [1:0] hist;
   } predict_pkt_t;

   typedef struct packed {
      logic       valid;
      logic       mp;
      logic       middle;
      logic       way;
      logic [1:0] hist;
   } br_info_t;

endpackage

//--- src/exu_top.sv
// Integer execute stage top joining operand select, ALU, history and pipe control
`timescale 1ns/1ps

module exu_top (
   input  logic                  clk,
   input  logic                  i_arst_n,
   input  logic [1:0]            i_data_en,          // {x, r}
   input  logic [1:0]            i_ctl_en,           // {x, r}
   input  exu_pkg::alu_pkt_t     i_ap,
   input  logic                  i_alu_decode_d,
   input  exu_pkg::predict_pkt_t i_predict_d,
   input  exu_pkg::byp_sel_t     i_byp_sel_rs1,
   input  exu_pkg::byp_sel_t     i_byp_sel_rs2,
   input  exu_pkg::byp_data_t    i_byp_data,
   input  exu_pkg::word_t        i_gpr_rs1,
   input  exu_pkg::word_t        i_gpr_rs2,
   input  exu_pkg::word_t        i_immed,
   input  logic                  i_rs1_en,
   input  logic                  i_rs2_en,
   input  logic                  i_select_pc,
   input  exu_pkg::pc_t          i_pc_d,
   input  logic [12:1]           i_br_immed,
   input  exu_pkg::pc_t          i_pred_correct_npc_x,
   input  logic                  i_flush_lower_r,    // Trap flush from R
   input  exu_pkg::pc_t          i_flush_path_r,
   output exu_pkg::word_t        o_i0_result_x,
   output exu_pkg::pc_t          o_i0_pc_x,
   output logic                  o_flush_final,
   output exu_pkg::pc_t          o_flush_path_final,
   output exu_pkg::predict_pkt_t o_mp_pkt,
   output exu_pkg::ghr_t         o_mp_fghr,
   output exu_pkg::br_info_t     o_br_r,
   output exu_pkg::pc_t          o_npc_r
);

   exu_pkg::word_t        rs1_d;
   exu_pkg::word_t        rs2_d;
   logic                  flush_upper_d;
   exu_pkg::pc_t          flush_path_d;
   exu_pkg::predict_pkt_t predict_d;
   logic                  pred_correct_d;
   logic                  flush_upper_x;
   logic                  br_valid_x;
   logic                  br_taken_x;
   logic                  ctl_en_x;
   logic                  data_en_x;

   exu_operand_mux u_operand_mux (
      .i_byp_sel_rs1 (i_byp_sel_rs1),
      .i_byp_sel_rs2 (i_byp_sel_rs2),
      .i_byp_data    (i_byp_data),
      .i_result_x    (o_i0_result_x),    // X bypass source
      .i_gpr_rs1     (i_gpr_rs1),
      .i_gpr_rs2     (i_gpr_rs2),
      .i_immed       (i_immed),
      .i_rs1_en      (i_rs1_en),
      .i_rs2_en      (i_rs2_en),
      .i_select_pc   (i_select_pc),
      .i_pc_d        (i_pc_d),
      .o_rs1_d       (rs1_d),
      .o_rs2_d       (rs2_d)
   );

   exu_alu u_alu (
      .clk              (clk),
      .i_arst_n         (i_arst_n),
      .i_enable         (data_en_x),
      .i_valid_d        (i_alu_decode_d),
      .i_ap             (i_ap),
      .i_a              (rs1_d),
      .i_b              (rs2_d),
      .i_pc_d           (i_pc_d),
      .i_br_immed       (i_br_immed),
      .i_predict_d      (i_predict_d),
      .i_flush_upper_x  (flush_upper_x),
      .i_flush_lower_r  (i_flush_lower_r),
      .o_result_x       (o_i0_result_x),
      .o_pc_x           (o_i0_pc_x),
      .o_flush_upper_d  (flush_upper_d),
      .o_flush_path_d   (flush_path_d),
      .o_predict_d      (predict_d),
      .o_pred_correct_d (pred_correct_d)
   );

   exu_ghr u_ghr (
      .clk             (clk),
      .i_arst_n        (i_arst_n),
      .i_ctl_en_x      (ctl_en_x),
      .i_predict_d     (predict_d),
      .i_valid_d       (i_alu_decode_d),
      .i_br_valid_x    (br_valid_x),
      .i_br_taken_x    (br_taken_x),
      .i_flush_upper_x (flush_upper_x),
      .i_flush_lower_r (i_flush_lower_r),
      .o_mp_fghr       (o_mp_fghr)
   );

   exu_pipe_ctl u_pipe_ctl (
      .clk                  (clk),
      .i_arst_n             (i_arst_n),
      .i_data_en            (i_data_en),
      .i_ctl_en             (i_ctl_en),
      .i_flush_upper_d      (flush_upper_d),
      .i_flush_path_d       (flush_path_d),
      .i_predict_d          (predict_d),
      .i_pred_correct_d     (pred_correct_d),
      .i_flush_lower_r      (i_flush_lower_r),
      .i_flush_path_r       (i_flush_path_r),
      .i_pred_correct_npc_x (i_pred_correct_npc_x),
      .o_ctl_en_x           (ctl_en_x),
      .o_data_en_x          (data_en_x),
      .o_flush_upper_x      (flush_upper_x),
      .o_br_valid_x         (br_valid_x),
      .o_br_taken_x         (br_taken_x),
      .o_flush_final        (o_flush_final),
      .o_flush_path_final   (o_flush_path_final),
      .o_mp_pkt             (o_mp_pkt),
      .o_br_r               (o_br_r),
      .o_npc_r              (o_npc_r)
   );

endmodule
